// ==== qdr_defines.svh ====
`ifndef QDR_DEFINES_SVH
`define QDR_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// RAM geometry

// One beat on a single data lane, 32 data bits plus 4 parity
`define QDR_LANE_WIDTH		36

// Host address, low bits pick the channel
`define QDR_ADDR_BITS		19
`define QDR_NUM_CHANNELS	2
`define QDR_CHAN_BITS		1

//////////////////////////////////////////////////////////////////////
// Timing and buffering

// Cycles from the read select to the first QVLD beat pair
`define QDR_READ_LATENCY	3
`define QDR_RET_DEPTH		4
`define QDR_ORDER_DEPTH		8

`endif

// ==== qdr_pkg.sv ====
`default_nettype none

`include "qdr_defines.svh"

package qdr_pkg;

	// Four beats of one burst, beat 0 in the top lane slot
	typedef logic [4*`QDR_LANE_WIDTH-1:0] qdr_burst_t;

	// Address as seen by the host
	typedef logic [`QDR_ADDR_BITS-1:0] qdr_addr_t;

	// Address on one SRAM, channel bits stripped
	typedef logic [`QDR_ADDR_BITS-`QDR_CHAN_BITS-1:0] qdr_ram_addr_t;

	// Channel index, also the tag kept by the read merger
	typedef logic [`QDR_CHAN_BITS-1:0] qdr_chan_t;

endpackage

`default_nettype wire

// ==== qdr_sync_fifo.sv ====
`default_nettype none
`timescale 1ns/1ps

module qdr_sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 4,
	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1,
	localparam int CNT_BITS = $clog2(DEPTH + 1)
) (
	input wire clk_ctl,
	input wire rst,
	input wire in_valid,
	output logic in_ready,
	input wire payload_t in_data,
	output logic out_valid,
	input wire out_ready,
	output payload_t out_data,
	output logic [CNT_BITS-1:0] count
);

	localparam logic [PTR_BITS-1:0] LAST_PTR = PTR_BITS'(DEPTH - 1);
	localparam logic [CNT_BITS-1:0] FULL_COUNT = CNT_BITS'(DEPTH);

	payload_t mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic push;
	logic pop;

	// Head word is visible as soon as it lands, no read cycle
	assign in_ready = (count != FULL_COUNT);
	assign out_valid = (count != '0);
	assign out_data = mem[rd_ptr];
	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;

	always_ff @(posedge clk_ctl) begin
		if (push)
			mem[wr_ptr] <= in_data;
	end

	// Pointers wrap at DEPTH, so any depth works
	always_ff @(posedge clk_ctl) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Upstream flow control never offers a word into a full buffer
	a_no_push_full: assert property (@(posedge clk_ctl) disable iff (rst)
		in_valid |-> in_ready);

endmodule

`default_nettype wire

// ==== qdr_req_dispatch.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "qdr_defines.svh"

module qdr_req_dispatch (
	input wire clk_ctl,
	input wire rst,
	input wire cmd_valid,
	output logic cmd_ready,
	input wire cmd_write,
	input wire qdr_pkg::qdr_addr_t cmd_addr,
	input wire qdr_pkg::qdr_burst_t cmd_wdata,
	output logic [`QDR_NUM_CHANNELS-1:0] chan_valid,
	input wire [`QDR_NUM_CHANNELS-1:0] chan_ready,
	output logic chan_write,
	output qdr_pkg::qdr_ram_addr_t chan_addr,
	output qdr_pkg::qdr_burst_t chan_wdata,
	output logic ord_valid,
	output qdr_pkg::qdr_chan_t ord_chan,
	input wire ord_ready
);
	import qdr_pkg::*;

	qdr_chan_t sel_chan;
	logic sel_ready;
	logic order_ok;

	//////////////////////////////////////////////////////////////////////
	// Address split

	// Low bits interleave bursts across the SRAMs
	assign sel_chan = cmd_addr[`QDR_CHAN_BITS-1:0];
	assign chan_addr = cmd_addr[`QDR_ADDR_BITS-1:`QDR_CHAN_BITS];

	// Payload goes to every channel, only valid is steered
	assign chan_write = cmd_write;
	assign chan_wdata = cmd_wdata;

	//////////////////////////////////////////////////////////////////////
	// Handshake steering

	// Reads also need a free slot in the merger's tag FIFO
	assign sel_ready = chan_ready[sel_chan];
	assign order_ok = cmd_write || ord_ready;
	assign cmd_ready = sel_ready && order_ok;

	always_comb begin
		chan_valid = '0;
		chan_valid[sel_chan] = cmd_valid && order_ok;
	end

	// Tag is pushed in the same cycle the read is taken
	assign ord_valid = cmd_valid && !cmd_write && sel_ready && ord_ready;
	assign ord_chan = sel_chan;

	// A stalled host command must not change under us
	a_cmd_hold: assert property (@(posedge clk_ctl) disable iff (rst)
		(cmd_valid && !cmd_ready) |=> (cmd_valid && $stable(cmd_write)
			&& $stable(cmd_addr) && $stable(cmd_wdata)));

endmodule

`default_nettype wire

// ==== qdr_channel_ctl.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "qdr_defines.svh"

module qdr_channel_ctl (
	input wire clk_ctl,
	input wire rst,
	input wire chan_valid,
	output logic chan_ready,
	input wire chan_write,
	input wire qdr_pkg::qdr_ram_addr_t chan_addr,
	input wire qdr_pkg::qdr_burst_t chan_wdata,
	output logic ret_valid,
	input wire ret_ready,
	output qdr_pkg::qdr_burst_t ret_data,
	output logic qdr_rps_n,
	output logic qdr_wps_n,
	output qdr_pkg::qdr_ram_addr_t qdr_a,
	output logic [3:0] qdr_bws_n,
	output logic [`QDR_LANE_WIDTH-1:0] qdr_d_lo,
	output logic [`QDR_LANE_WIDTH-1:0] qdr_d_hi,
	input wire [`QDR_LANE_WIDTH-1:0] qdr_q_lo,
	input wire [`QDR_LANE_WIDTH-1:0] qdr_q_hi,
	input wire qdr_qvld
);
	import qdr_pkg::*;

	localparam int LW = `QDR_LANE_WIDTH;
	localparam int CRED_BITS = $clog2(`QDR_RET_DEPTH + 1);
	localparam logic [CRED_BITS:0] CRED_LIMIT = (CRED_BITS + 1)'(`QDR_RET_DEPTH);

	logic slot_free;
	logic accept;
	logic rd_accept;
	logic [CRED_BITS-1:0] rd_pending;
	logic [CRED_BITS-1:0] fifo_count;
	logic [CRED_BITS:0] credit_used;
	logic credit_ok;
	qdr_burst_t wr_burst;
	logic wr_second;
	logic [2*LW-1:0] first_pair;
	logic pair_open;
	qdr_burst_t ret_word;
	logic ret_push;

	//////////////////////////////////////////////////////////////////////
	// Command side

	assign accept = chan_valid && chan_ready;
	assign rd_accept = accept && !chan_write;

	// Reads in flight plus words parked in the FIFO may not exceed its depth
	assign credit_used = {1'b0, rd_pending} + {1'b0, fifo_count};
	assign credit_ok = (credit_used < CRED_LIMIT);

	// One burst takes two cycles, so skip the cycle after any accept
	assign chan_ready = slot_free && (chan_write || credit_ok);

	always_ff @(posedge clk_ctl) begin
		if (rst) begin
			slot_free <= 1'b0;
			qdr_rps_n <= 1'b1;
			qdr_wps_n <= 1'b1;
		end else begin
			slot_free <= !accept;
			qdr_rps_n <= !rd_accept;
			qdr_wps_n <= !(accept && chan_write);
		end
	end

	// Address follows the select, burst kept for the data phases
	always_ff @(posedge clk_ctl) begin
		if (accept)
			qdr_a <= chan_addr;
		if (accept && chan_write)
			wr_burst <= chan_wdata;
	end

	//////////////////////////////////////////////////////////////////////
	// Write data sequencer

	// Beats 0/1 the cycle after WPS#, beats 2/3 the cycle after that
	always_ff @(posedge clk_ctl) begin
		if (rst) begin
			wr_second <= 1'b0;
			qdr_d_lo <= '0;
			qdr_d_hi <= '0;
			qdr_bws_n <= 4'hf;
		end else if (!qdr_wps_n) begin
			qdr_d_lo <= wr_burst[4*LW-1 -: LW];
			qdr_d_hi <= wr_burst[3*LW-1 -: LW];
			qdr_bws_n <= 4'h0;
			wr_second <= 1'b1;
		end else if (wr_second) begin
			qdr_d_lo <= wr_burst[2*LW-1 -: LW];
			qdr_d_hi <= wr_burst[LW-1 -: LW];
			qdr_bws_n <= 4'h0;
			wr_second <= 1'b0;
		end else begin
			// Quiet bus between bursts
			qdr_d_lo <= '0;
			qdr_d_hi <= '0;
			qdr_bws_n <= 4'hf;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read return pairing

	// QVLD comes in pairs; odd beat pair opens, even one closes the word
	always_ff @(posedge clk_ctl) begin
		if (rst) begin
			pair_open <= 1'b0;
			ret_push <= 1'b0;
		end else begin
			ret_push <= qdr_qvld && pair_open;
			if (qdr_qvld)
				pair_open <= !pair_open;
		end
	end

	always_ff @(posedge clk_ctl) begin
		if (qdr_qvld && !pair_open)
			first_pair <= {qdr_q_lo, qdr_q_hi};
		if (qdr_qvld && pair_open)
			ret_word <= {first_pair, qdr_q_lo, qdr_q_hi};
	end

	// Credit count drops when the word reaches the FIFO
	always_ff @(posedge clk_ctl) begin
		if (rst)
			rd_pending <= '0;
		else if (rd_accept && !ret_push)
			rd_pending <= rd_pending + 1'b1;
		else if (!rd_accept && ret_push)
			rd_pending <= rd_pending - 1'b1;
	end

	qdr_sync_fifo #(
		.payload_t(qdr_burst_t),
		.DEPTH(`QDR_RET_DEPTH)
	) u_ret_fifo (
		.clk_ctl(clk_ctl),
		.rst(rst),
		.in_valid(ret_push),
		.in_ready(),
		.in_data(ret_word),
		.out_valid(ret_valid),
		.out_ready(ret_ready),
		.out_data(ret_data),
		.count(fifo_count)
	);

	// The SRAM never returns half a burst
	a_qvld_pairs: assert property (@(posedge clk_ctl) disable iff (rst)
		$rose(qdr_qvld) |=> qdr_qvld);

	// A burst owns the RAM for two cycles, no select right behind another
	a_select_spacing: assert property (@(posedge clk_ctl) disable iff (rst)
		(!qdr_rps_n || !qdr_wps_n) |=> (qdr_rps_n && qdr_wps_n));

endmodule

`default_nettype wire

// ==== qdr_read_merge.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "qdr_defines.svh"

module qdr_read_merge (
	input wire clk_ctl,
	input wire rst,
	input wire ord_valid,
	output logic ord_ready,
	input wire qdr_pkg::qdr_chan_t ord_chan,
	input wire [`QDR_NUM_CHANNELS-1:0] ret_valid,
	output logic [`QDR_NUM_CHANNELS-1:0] ret_ready,
	input wire qdr_pkg::qdr_burst_t ret_data [`QDR_NUM_CHANNELS],
	output logic rd_valid,
	input wire rd_ready,
	output qdr_pkg::qdr_burst_t rd_data
);
	import qdr_pkg::*;

	localparam int TAG_CNT_BITS = $clog2(`QDR_ORDER_DEPTH + 1);

	logic head_valid;
	qdr_chan_t head_chan;
	logic [TAG_CNT_BITS-1:0] tag_count;
	logic host_xfer;

	// Tags in issue order, one per accepted read
	qdr_sync_fifo #(
		.payload_t(qdr_chan_t),
		.DEPTH(`QDR_ORDER_DEPTH)
	) u_order_fifo (
		.clk_ctl(clk_ctl),
		.rst(rst),
		.in_valid(ord_valid),
		.in_ready(ord_ready),
		.in_data(ord_chan),
		.out_valid(head_valid),
		.out_ready(host_xfer),
		.out_data(head_chan),
		.count(tag_count)
	);

	//////////////////////////////////////////////////////////////////////
	// Head channel to host

	// Other channels just wait, their credits hold off new reads
	assign rd_valid = head_valid && ret_valid[head_chan];
	assign rd_data = ret_data[head_chan];
	assign host_xfer = rd_valid && rd_ready;

	always_comb begin
		ret_ready = '0;
		ret_ready[head_chan] = head_valid && rd_ready;
	end

	// A word parked in any channel still has its tag queued
	a_word_has_tag: assert property (@(posedge clk_ctl) disable iff (rst)
		(ret_valid != '0) |-> (tag_count != '0));

endmodule

`default_nettype wire

// ==== qdr_subsystem_top.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "qdr_defines.svh"

module qdr_subsystem_top (
	input wire clk_ctl,
	input wire rst,
	// Host command and read return
	input wire cmd_valid,
	output logic cmd_ready,
	input wire cmd_write,
	input wire qdr_pkg::qdr_addr_t cmd_addr,
	input wire qdr_pkg::qdr_burst_t cmd_wdata,
	output logic rd_valid,
	input wire rd_ready,
	output qdr_pkg::qdr_burst_t rd_data,
	// One SRAM per index
	output logic [`QDR_NUM_CHANNELS-1:0] qdr_rps_n,
	output logic [`QDR_NUM_CHANNELS-1:0] qdr_wps_n,
	output qdr_pkg::qdr_ram_addr_t qdr_a [`QDR_NUM_CHANNELS],
	output logic [3:0] qdr_bws_n [`QDR_NUM_CHANNELS],
	output logic [`QDR_LANE_WIDTH-1:0] qdr_d_lo [`QDR_NUM_CHANNELS],
	output logic [`QDR_LANE_WIDTH-1:0] qdr_d_hi [`QDR_NUM_CHANNELS],
	input wire [`QDR_LANE_WIDTH-1:0] qdr_q_lo [`QDR_NUM_CHANNELS],
	input wire [`QDR_LANE_WIDTH-1:0] qdr_q_hi [`QDR_NUM_CHANNELS],
	input wire [`QDR_NUM_CHANNELS-1:0] qdr_qvld
);
	import qdr_pkg::*;

	logic [`QDR_NUM_CHANNELS-1:0] chan_valid;
	logic [`QDR_NUM_CHANNELS-1:0] chan_ready;
	logic chan_write;
	qdr_ram_addr_t chan_addr;
	qdr_burst_t chan_wdata;
	logic ord_valid;
	logic ord_ready;
	qdr_chan_t ord_chan;
	logic [`QDR_NUM_CHANNELS-1:0] ret_valid;
	logic [`QDR_NUM_CHANNELS-1:0] ret_ready;
	qdr_burst_t ret_data [`QDR_NUM_CHANNELS];

	qdr_req_dispatch u_req_dispatch (
		.clk_ctl(clk_ctl),
		.rst(rst),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.cmd_write(cmd_write),
		.cmd_addr(cmd_addr),
		.cmd_wdata(cmd_wdata),
		.chan_valid(chan_valid),
		.chan_ready(chan_ready),
		.chan_write(chan_write),
		.chan_addr(chan_addr),
		.chan_wdata(chan_wdata),
		.ord_valid(ord_valid),
		.ord_chan(ord_chan),
		.ord_ready(ord_ready)
	);

	//////////////////////////////////////////////////////////////////////
	// Channel controllers

	for (genvar i = 0; i < `QDR_NUM_CHANNELS; i++) begin : g_chan
		qdr_channel_ctl u_channel_ctl (
			.clk_ctl(clk_ctl),
			.rst(rst),
			.chan_valid(chan_valid[i]),
			.chan_ready(chan_ready[i]),
			.chan_write(chan_write),
			.chan_addr(chan_addr),
			.chan_wdata(chan_wdata),
			.ret_valid(ret_valid[i]),
			.ret_ready(ret_ready[i]),
			.ret_data(ret_data[i]),
			.qdr_rps_n(qdr_rps_n[i]),
			.qdr_wps_n(qdr_wps_n[i]),
			.qdr_a(qdr_a[i]),
			.qdr_bws_n(qdr_bws_n[i]),
			.qdr_d_lo(qdr_d_lo[i]),
			.qdr_d_hi(qdr_d_hi[i]),
			.qdr_q_lo(qdr_q_lo[i]),
			.qdr_q_hi(qdr_q_hi[i]),
			.qdr_qvld(qdr_qvld[i])
		);
	end

	// Reorder point, host sees reads in issue order
	qdr_read_merge u_read_merge (
		.clk_ctl(clk_ctl),
		.rst(rst),
		.ord_valid(ord_valid),
		.ord_ready(ord_ready),
		.ord_chan(ord_chan),
		.ret_valid(ret_valid),
		.ret_ready(ret_ready),
		.ret_data(ret_data),
		.rd_valid(rd_valid),
		.rd_ready(rd_ready),
		.rd_data(rd_data)
	);

endmodule

`default_nettype wire

// ==== qdr_sram_model.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "qdr_defines.svh"

module qdr_sram_model (
	input wire clk_ctl,
	input wire rst,
	input wire qdr_rps_n,
	input wire qdr_wps_n,
	input wire qdr_pkg::qdr_ram_addr_t qdr_a,
	input wire [3:0] qdr_bws_n,
	input wire [`QDR_LANE_WIDTH-1:0] qdr_d_lo,
	input wire [`QDR_LANE_WIDTH-1:0] qdr_d_hi,
	output logic [`QDR_LANE_WIDTH-1:0] qdr_q_lo,
	output logic [`QDR_LANE_WIDTH-1:0] qdr_q_hi,
	output logic qdr_qvld
);
	import qdr_pkg::*;

	localparam int LW = `QDR_LANE_WIDTH;
	localparam int LAT = `QDR_READ_LATENCY;

	// Sparse storage, only touched addresses exist
	qdr_burst_t mem [qdr_ram_addr_t];
	// Stage k holds the read selected k cycles ago
	logic rd_v [1:LAT];
	qdr_ram_addr_t rd_a [1:LAT];
	qdr_ram_addr_t wr_addr;
	logic wr_second;
	qdr_burst_t word;

	// Untouched locations read back a pattern built from the address
	function automatic qdr_burst_t read_word(input qdr_ram_addr_t a);
		if (mem.exists(a))
			return mem[a];
		return qdr_burst_t'({8{~a}});
	endfunction

	always @(posedge clk_ctl) begin
		if (rst) begin
			qdr_qvld <= 1'b0;
			qdr_q_lo <= '0;
			qdr_q_hi <= '0;
			wr_second = 1'b0;
			for (int k = 1; k <= LAT; k++)
				rd_v[k] = 1'b0;
		end else begin
			//////////////////////////////////////////////////////////////////////
			// Read return, beats 0/1 then beats 2/3 with QVLD
			if (rd_v[LAT-1]) begin
				word = read_word(rd_a[LAT-1]);
				qdr_qvld <= 1'b1;
				qdr_q_lo <= word[4*LW-1 -: LW];
				qdr_q_hi <= word[3*LW-1 -: LW];
			end else if (rd_v[LAT]) begin
				word = read_word(rd_a[LAT]);
				qdr_qvld <= 1'b1;
				qdr_q_lo <= word[2*LW-1 -: LW];
				qdr_q_hi <= word[LW-1 -: LW];
			end else begin
				qdr_qvld <= 1'b0;
				qdr_q_lo <= '0;
				qdr_q_hi <= '0;
			end
			for (int k = LAT; k > 1; k--) begin
				rd_v[k] = rd_v[k-1];
				rd_a[k] = rd_a[k-1];
			end
			rd_v[1] = !qdr_rps_n;
			rd_a[1] = qdr_a;

			//////////////////////////////////////////////////////////////////////
			// Write data, first strobed pair is the top half
			if (qdr_bws_n == 4'h0) begin
				word = read_word(wr_addr);
				if (!wr_second)
					word[4*LW-1 -: 2*LW] = {qdr_d_lo, qdr_d_hi};
				else
					word[2*LW-1:0] = {qdr_d_lo, qdr_d_hi};
				mem[wr_addr] = word;
				wr_second = !wr_second;
			end
			// New write address after the old burst finished its last pair
			if (!qdr_wps_n) begin
				wr_addr = qdr_a;
				wr_second = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS = 40,
	parameter int RESET_CYCLES = 8
) (
	output logic clk_ctl,
	output logic rst
);

	initial begin
		clk_ctl = 1'b0;
		forever #(PERIOD_NS / 2) clk_ctl = ~clk_ctl;
	end

	// Release just after an edge, like every other driven input
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_ctl);
		#2;
		rst = 1'b0;
	end

endmodule

`default_nettype wire

// ==== qdr_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "qdr_defines.svh"

module qdr_tb;
	import qdr_pkg::*;

	localparam int NCH = `QDR_NUM_CHANNELS;
	localparam int LW = `QDR_LANE_WIDTH;
	// Accept, select, RAM latency, beat pairing, FIFO write
	localparam int IDLE_READ_CYCLES = 1 + 1 + `QDR_READ_LATENCY + 2;
	// All tests together need a few hundred cycles
	localparam int TIMEOUT_CYCLES = 4000;
	localparam int WR_RD_SPACING = 4;
	localparam int RANDOM_CMDS = 40;
	localparam int HOLD_CYCLES = 20;

	logic clk_ctl;
	logic rst;
	logic cmd_valid;
	wire cmd_ready;
	logic cmd_write;
	qdr_addr_t cmd_addr;
	qdr_burst_t cmd_wdata;
	wire rd_valid;
	logic rd_ready;
	wire qdr_burst_t rd_data;
	wire [NCH-1:0] qdr_rps_n;
	wire [NCH-1:0] qdr_wps_n;
	wire [NCH-1:0] qdr_qvld;
	wire qdr_ram_addr_t qdr_a [NCH];
	wire [3:0] qdr_bws_n [NCH];
	wire [LW-1:0] qdr_d_lo [NCH];
	wire [LW-1:0] qdr_d_hi [NCH];
	wire [LW-1:0] qdr_q_lo [NCH];
	wire [LW-1:0] qdr_q_hi [NCH];

	// Scoreboard, keyed by host address
	qdr_burst_t ref_mem [qdr_addr_t];
	int wr_cycle [qdr_addr_t];
	qdr_burst_t exp_q [$];
	qdr_burst_t mon_exp;

	int seed = 32'h5341;
	int cycle_cnt = 0;
	int check_cnt = 0;
	int err_cnt = 0;
	int rd_cnt = 0;
	int test_err0;
	int test_chk0;
	// Read port throttle controls
	int hold_cycles;
	logic throttle;
	logic hold_now;
	logic [31:0] coin;

	tb_clock_gen #(
		.PERIOD_NS(40),
		.RESET_CYCLES(8)
	) u_clock_gen (
		.clk_ctl(clk_ctl),
		.rst(rst)
	);

	qdr_subsystem_top u_qdr_subsystem_top (
		.clk_ctl(clk_ctl),
		.rst(rst),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.cmd_write(cmd_write),
		.cmd_addr(cmd_addr),
		.cmd_wdata(cmd_wdata),
		.rd_valid(rd_valid),
		.rd_ready(rd_ready),
		.rd_data(rd_data),
		.qdr_rps_n(qdr_rps_n),
		.qdr_wps_n(qdr_wps_n),
		.qdr_a(qdr_a),
		.qdr_bws_n(qdr_bws_n),
		.qdr_d_lo(qdr_d_lo),
		.qdr_d_hi(qdr_d_hi),
		.qdr_q_lo(qdr_q_lo),
		.qdr_q_hi(qdr_q_hi),
		.qdr_qvld(qdr_qvld)
	);

	for (genvar i = 0; i < NCH; i++) begin : g_sram
		qdr_sram_model u_sram_model (
			.clk_ctl(clk_ctl),
			.rst(rst),
			.qdr_rps_n(qdr_rps_n[i]),
			.qdr_wps_n(qdr_wps_n[i]),
			.qdr_a(qdr_a[i]),
			.qdr_bws_n(qdr_bws_n[i]),
			.qdr_d_lo(qdr_d_lo[i]),
			.qdr_d_hi(qdr_d_hi[i]),
			.qdr_q_lo(qdr_q_lo[i]),
			.qdr_q_hi(qdr_q_hi[i]),
			.qdr_qvld(qdr_qvld[i])
		);
	end

	//////////////////////////////////////////////////////////////////////
	// Cycle count and run limit

	always @(posedge clk_ctl) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the tests did not complete", cycle_cnt);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// Read port ready, hold window first, then optional coin toss
	always @(posedge clk_ctl) begin
		hold_now = (hold_cycles != 0);
		if (hold_cycles != 0)
			hold_cycles--;
		coin = throttle ? $random(seed) : 32'h1;
		#2;
		rd_ready = !hold_now && coin[0];
	end

	// Every word taken by the host is compared in issue order
	always @(negedge clk_ctl) begin
		if (!rst && rd_valid && rd_ready) begin
			rd_cnt++;
			check_cnt++;
			if (exp_q.size() == 0) begin
				err_cnt++;
				$display("Read data came back at %0t with no read outstanding", $time);
			end else begin
				mon_exp = exp_q.pop_front();
				if (rd_data !== mon_exp) begin
					err_cnt++;
					$display("ERR %0t: rd_data %h, expected %h", $time, rd_data, mon_exp);
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers

	function automatic qdr_burst_t random_burst();
		logic [159:0] raw;
		raw = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
		return qdr_burst_t'(raw);
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk_ctl);
			#2;
		end
	endtask

	// Called at a drive point, returns at the next one after the transfer
	task automatic send_cmd(input logic write, input qdr_addr_t addr, input qdr_burst_t data,
			output int accept_cycle, output int stall_cycles);
		cmd_valid = 1'b1;
		cmd_write = write;
		cmd_addr = addr;
		cmd_wdata = data;
		stall_cycles = 0;
		@(negedge clk_ctl);
		while (!cmd_ready) begin
			stall_cycles++;
			@(negedge clk_ctl);
		end
		accept_cycle = cycle_cnt;
		@(posedge clk_ctl);
		#2;
		cmd_valid = 1'b0;
		if (write) begin
			ref_mem[addr] = data;
			wr_cycle[addr] = accept_cycle;
		end else begin
			exp_q.push_back(ref_mem[addr]);
		end
	endtask

	// No read forwarding, so keep reads clear of recent writes
	task automatic wait_write_spacing(input qdr_addr_t addr);
		if (wr_cycle.exists(addr)) begin
			while (cycle_cnt < wr_cycle[addr] + WR_RD_SPACING)
				idle_cycles(1);
		end
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0)
			idle_cycles(1);
	endtask

	task automatic start_test();
		test_err0 = err_cnt;
		test_chk0 = check_cnt;
	endtask

	task automatic report_test(input string name);
		int errs;
		int checks;
		errs = err_cnt - test_err0;
		checks = check_cnt - test_chk0;
		if (errs == 0)
			$display("test %s: pass, %0d checks", name, checks);
		else
			$display("test %s: FAIL, %0d of %0d checks wrong", name, errs, checks);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests

	task automatic reset_behavior();
		int waited;
		start_test();
		@(negedge clk_ctl);
		while (rst) begin
			check_cnt++;
			if (cmd_ready !== 1'b0 || rd_valid !== 1'b0) begin
				err_cnt++;
				$display("ERR %0t: cmd_ready %b rd_valid %b in reset", $time, cmd_ready,
					rd_valid);
			end
			// Selects and strobes high, data lanes quiet
			for (int i = 0; i < NCH; i++) begin
				check_cnt++;
				if (qdr_rps_n[i] !== 1'b1 || qdr_wps_n[i] !== 1'b1
						|| qdr_bws_n[i] !== 4'hf || qdr_d_lo[i] !== '0
						|| qdr_d_hi[i] !== '0) begin
					err_cnt++;
					$display("ERR %0t: RAM port %0d not idle in reset", $time, i);
				end
			end
			@(negedge clk_ctl);
		end
		waited = 0;
		while (cmd_ready !== 1'b1 && waited < 4) begin
			waited++;
			@(negedge clk_ctl);
		end
		check_cnt++;
		if (cmd_ready !== 1'b1) begin
			err_cnt++;
			$display("ERR %0t: cmd_ready still low after reset", $time);
		end
		@(posedge clk_ctl);
		#2;
		report_test("reset");
	endtask

	task automatic single_write_read();
		qdr_addr_t addr;
		int acc;
		int stall;
		int waited;
		start_test();
		addr = 19'h01235;
		send_cmd(1'b1, addr, random_burst(), acc, stall);
		wait_write_spacing(addr);
		send_cmd(1'b0, addr, '0, acc, stall);
		// Idle pipeline, first data must land a fixed distance later
		waited = 0;
		@(negedge clk_ctl);
		while (!rd_valid && waited < 20) begin
			waited++;
			@(negedge clk_ctl);
		end
		check_cnt++;
		if (!rd_valid) begin
			err_cnt++;
			$display("Read data never arrived for the single read at %0t", $time);
		end else if (cycle_cnt - acc != IDLE_READ_CYCLES) begin
			err_cnt++;
			$display("ERR %0t: read latency %0d cycles, expected %0d", $time,
				cycle_cnt - acc, IDLE_READ_CYCLES);
		end
		@(posedge clk_ctl);
		#2;
		wait_drain();
		report_test("single write and read");
	endtask

	task automatic alternating_stream();
		qdr_addr_t base;
		int acc;
		int stall;
		int wr_stalls;
		int rd_before;
		start_test();
		base = 19'h00400;
		wr_stalls = 0;
		rd_before = rd_cnt;
		// Low address bit flips every command, so channels alternate
		for (int k = 0; k < 8; k++) begin
			send_cmd(1'b1, base + qdr_addr_t'(k), random_burst(), acc, stall);
			wr_stalls += stall;
		end
		check_cnt++;
		if (wr_stalls != 0) begin
			err_cnt++;
			$display("ERR %0t: %0d stall cycles in an alternating write stream", $time,
				wr_stalls);
		end
		for (int k = 0; k < 8; k++)
			send_cmd(1'b0, base + qdr_addr_t'(k), '0, acc, stall);
		wait_drain();
		check_cnt++;
		if (rd_cnt - rd_before != 8) begin
			err_cnt++;
			$display("ERR %0t: %0d reads returned, expected 8", $time, rd_cnt - rd_before);
		end
		report_test("alternating stream");
	endtask

	task automatic read_backpressure();
		qdr_addr_t base;
		int acc;
		int stall;
		int late_stall;
		int rd_before;
		start_test();
		base = 19'h00400;
		late_stall = 0;
		rd_before = rd_cnt;
		hold_cycles = HOLD_CYCLES;
		// Eight reads fill the credits and the order FIFO, the rest must wait
		for (int k = 0; k < 10; k++) begin
			send_cmd(1'b0, base + qdr_addr_t'(k % 8), '0, acc, stall);
			if (k >= 8)
				late_stall += stall;
		end
		check_cnt++;
		if (late_stall == 0) begin
			err_cnt++;
			$display("cmd_ready never stalled while the read port was held at %0t", $time);
		end
		wait_drain();
		check_cnt++;
		if (rd_cnt - rd_before != 10) begin
			err_cnt++;
			$display("ERR %0t: %0d reads returned, expected 10", $time, rd_cnt - rd_before);
		end
		report_test("read back-pressure");
	endtask

	task automatic random_traffic();
		qdr_addr_t base;
		qdr_addr_t addr;
		qdr_burst_t data;
		logic [31:0] rnd;
		logic do_write;
		int acc;
		int stall;
		int reads;
		int rd_before;
		start_test();
		base = 19'h2a3c0;
		reads = 0;
		rd_before = rd_cnt;
		throttle = 1'b1;
		for (int n = 0; n < RANDOM_CMDS; n++) begin
			rnd = $random(seed);
			addr = base + qdr_addr_t'(rnd[3:0]);
			// A never written address gets a write instead of a read
			do_write = rnd[8] || !ref_mem.exists(addr);
			data = '0;
			if (do_write) begin
				data = random_burst();
			end else begin
				wait_write_spacing(addr);
				reads++;
			end
			send_cmd(do_write, addr, data, acc, stall);
		end
		wait_drain();
		throttle = 1'b0;
		check_cnt++;
		if (rd_cnt - rd_before != reads) begin
			err_cnt++;
			$display("ERR %0t: %0d reads returned, expected %0d", $time, rd_cnt - rd_before,
				reads);
		end
		report_test("random traffic");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		cmd_valid = 1'b0;
		cmd_write = 1'b0;
		cmd_addr = '0;
		cmd_wdata = '0;
		rd_ready = 1'b0;
		throttle = 1'b0;
		hold_cycles = 0;
		reset_behavior();
		single_write_read();
		alternating_stream();
		read_backpressure();
		random_traffic();
		$display("Summary: %0d checks, %0d errors", check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== qdr.f ====
+incdir+.
qdr_pkg.sv
qdr_sync_fifo.sv
qdr_req_dispatch.sv
qdr_channel_ctl.sv
qdr_read_merge.sv
qdr_subsystem_top.sv
qdr_sram_model.sv
tb_clock_gen.sv
qdr_tb.sv

// ==== Makefile ====
# Verilator build and run for the QDR-II+ controller testbench

VERILATOR ?= verilator
TOP ?= qdr_tb
FILELIST ?= qdr.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= ALL CHECKS PASSED
VFLAGS ?= --binary --timing --assert -Wno-fatal

SIM_BIN = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST)) qdr_defines.svh

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides pass or fail
run: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
